// File: logic/pipe_macros.svh
`ifndef PIPE_MACROS_SVH
`define PIPE_MACROS_SVH

// Data path width
`define PIPE_XLEN 16

// Memory depths in words
`define PIPE_IMEM_DEPTH 32
`define PIPE_DMEM_DEPTH 16

// Instruction address and cycle counter widths
`define PIPE_PC_W 5
`define PIPE_CYCLE_W 16

`endif

// File: logic/pipe_pkg.sv
`include "pipe_macros.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_ADDI  = 4'h3,
        OP_LOAD  = 4'h4,
        OP_STORE = 4'h5,
        OP_NOP   = 4'hf
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND
    } alu_op_t;

    // Register form: rd = rs1 op rs2
    typedef struct packed {
        opcode_t    op;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic [2:0] rs2;
        logic [2:0] unused;
    } instr_r_t;

    // Immediate form, STORE takes its data register from rd
    typedef struct packed {
        opcode_t           op;
        logic [2:0]        rd;
        logic [2:0]        rs1;
        logic signed [5:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
    } ctrl_t;

    typedef struct packed {
        logic                  fetch_fire;
        logic [`PIPE_PC_W-1:0] fetch_pc;
        instr_u                fetch_instr;
        logic                  front_hold;
    } stage_status_t;

    typedef struct packed {
        logic [`PIPE_PC_W-1:0]    pc;
        instr_u                   instr;
        logic [`PIPE_CYCLE_W-1:0] fetch_cycle;
        logic [`PIPE_CYCLE_W-1:0] retire_cycle;
        logic [7:0]               hold_cycles;
        logic                     wrote;
        logic [2:0]               rd;
        logic [`PIPE_XLEN-1:0]    wb_data;
    } retire_t;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module instr_decoder (
    input  pipe_pkg::instr_u      instr,
    output pipe_pkg::ctrl_t       ctrl,
    output logic [2:0]            rd,
    output logic [2:0]            rs1,
    output logic [2:0]            rs2,
    output logic [`PIPE_XLEN-1:0] imm,
    output logic                  uses_rs2
);
    import pipe_pkg::*;

    always_comb begin
        // Anything not listed below decodes as a NOP
        ctrl     = '0;
        rd       = 3'd0;
        rs1      = 3'd0;
        rs2      = 3'd0;
        imm      = '0;
        uses_rs2 = 1'b0;
        case (instr.r.op)
            OP_ADD, OP_SUB, OP_AND: begin
                rd             = instr.r.rd;
                rs1            = instr.r.rs1;
                rs2            = instr.r.rs2;
                uses_rs2       = 1'b1;
                ctrl.reg_write = 1'b1;
                if (instr.r.op == OP_SUB) begin
                    ctrl.alu_op = ALU_SUB;
                end else if (instr.r.op == OP_AND) begin
                    ctrl.alu_op = ALU_AND;
                end else begin
                    ctrl.alu_op = ALU_ADD;
                end
            end
            OP_ADDI, OP_LOAD: begin
                rd             = instr.i.rd;
                rs1            = instr.i.rs1;
                imm            = {{(`PIPE_XLEN - 6){instr.i.imm[5]}}, instr.i.imm};
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = (instr.i.op == OP_LOAD);
            end
            OP_STORE: begin
                // Store data comes through the second operand port
                rs1            = instr.i.rs1;
                rs2            = instr.i.rd;
                uses_rs2       = 1'b1;
                imm            = {{(`PIPE_XLEN - 6){instr.i.imm[5]}}, instr.i.imm};
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/pipe_core.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipe_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    imem_we,
    input  logic [`PIPE_PC_W-1:0]   imem_addr,
    input  logic [`PIPE_XLEN-1:0]   imem_wdata,
    input  logic [`PIPE_PC_W:0]     prog_len,
    input  logic                    start,
    input  logic                    stall,
    output pipe_pkg::stage_status_t status,
    output logic                    wb_valid,
    output logic [2:0]              wb_rd,
    output logic [`PIPE_XLEN-1:0]   wb_data,
    output logic                    fetch_done
);
    import pipe_pkg::*;

    typedef struct packed {
        logic   valid;
        instr_u instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [2:0]            rd;
        logic [2:0]            rs1;
        logic [2:0]            rs2;
        logic [`PIPE_XLEN-1:0] imm;
        logic [`PIPE_XLEN-1:0] a;
        logic [`PIPE_XLEN-1:0] b;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [2:0]            rd;
        logic [`PIPE_XLEN-1:0] alu;
        logic [`PIPE_XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [2:0]            rd;
        logic [`PIPE_XLEN-1:0] data;
    } mem_wb_t;

    logic [`PIPE_XLEN-1:0] imem [`PIPE_IMEM_DEPTH];
    logic [`PIPE_XLEN-1:0] dmem [`PIPE_DMEM_DEPTH];
    logic [`PIPE_XLEN-1:0] regs [8];

    logic                                  active;
    logic [`PIPE_PC_W:0]                   fetch_cnt;
    logic [`PIPE_PC_W-1:0]                 pc;
    logic                                  fetch_new;
    logic                                  fetch_valid;
    instr_u                                fetch_word;
    logic                                  load_use;
    logic                                  front_hold;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;

    ctrl_t                                 dec_ctrl;
    logic [2:0]                            dec_rd;
    logic [2:0]                            dec_rs1;
    logic [2:0]                            dec_rs2;
    logic [`PIPE_XLEN-1:0]                 dec_imm;
    logic                                  dec_uses_rs2;
    logic [`PIPE_XLEN-1:0]                 rf_a;
    logic [`PIPE_XLEN-1:0]                 rf_b;
    logic [`PIPE_XLEN-1:0]                 fwd_a;
    logic [`PIPE_XLEN-1:0]                 fwd_b;
    logic [`PIPE_XLEN-1:0]                 alu_b;
    logic [`PIPE_XLEN-1:0]                 alu_out;
    logic [$clog2(`PIPE_DMEM_DEPTH)-1:0]   dmem_addr;
    logic [`PIPE_XLEN-1:0]                 mem_result;

    // Operand bypass from memory stage first, then writeback
    function automatic logic [`PIPE_XLEN-1:0] forward(input logic [2:0] rs,
                                                      input logic [`PIPE_XLEN-1:0] rf_val);
        logic [`PIPE_XLEN-1:0] val;
        val = rf_val;
        if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.rd != 3'd0 && ex_mem.rd == rs) begin
            val = mem_result;
        end else if (mem_wb.valid && mem_wb.reg_write && mem_wb.rd != 3'd0
                     && mem_wb.rd == rs) begin
            val = mem_wb.data;
        end
        return val;
    endfunction

    // Program load
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Fetch
    assign pc          = fetch_cnt[`PIPE_PC_W-1:0];
    assign fetch_valid = active && (fetch_cnt < prog_len);
    assign fetch_done  = active && !(fetch_cnt < prog_len);
    assign fetch_word  = imem[pc];

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            fetch_cnt <= '0;
            fetch_new <= 1'b0;
        end else if (start) begin
            active    <= 1'b1;
            fetch_cnt <= '0;
            fetch_new <= 1'b1;
        end else begin
            // A held PC is presented again next cycle but is not a new fetch
            fetch_new <= !front_hold;
            if (fetch_valid && !front_hold) begin
                fetch_cnt <= fetch_cnt + 1'b1;
            end
        end
    end

    assign load_use = if_id.valid && id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != 3'd0
                      && (id_ex.rd == dec_rs1 || (dec_uses_rs2 && id_ex.rd == dec_rs2));
    assign front_hold = stall || load_use;

    assign status.fetch_fire  = fetch_valid && fetch_new;
    assign status.fetch_pc    = pc;
    assign status.fetch_instr = fetch_word;
    assign status.front_hold  = front_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id.valid <= 1'b0;
        end else if (!front_hold) begin
            if_id.valid <= fetch_valid;
            if_id.instr <= fetch_word;
        end
    end

    // Decode
    instr_decoder dec_i (
        .instr    (if_id.instr),
        .ctrl     (dec_ctrl),
        .rd       (dec_rd),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .imm      (dec_imm),
        .uses_rs2 (dec_uses_rs2)
    );

    always_comb begin
        rf_a = regs[dec_rs1];
        rf_b = regs[dec_rs2];
        // Same-cycle writeback is not yet in the register file
        if (wb_valid && wb_rd != 3'd0 && wb_rd == dec_rs1) begin
            rf_a = wb_data;
        end
        if (wb_valid && wb_rd != 3'd0 && wb_rd == dec_rs2) begin
            rf_b = wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid <= 1'b0;
        end else begin
            // Bubble while the front is held
            id_ex.valid <= if_id.valid && !front_hold;
            id_ex.ctrl  <= dec_ctrl;
            id_ex.rd    <= dec_rd;
            id_ex.rs1   <= dec_rs1;
            id_ex.rs2   <= dec_rs2;
            id_ex.imm   <= dec_imm;
            id_ex.a     <= rf_a;
            id_ex.b     <= rf_b;
        end
    end

    // Execute
    always_comb begin
        fwd_a = forward(id_ex.rs1, id_ex.a);
        fwd_b = forward(id_ex.rs2, id_ex.b);
    end

    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB: alu_out = fwd_a - alu_b;
            ALU_AND: alu_out = fwd_a & alu_b;
            default: alu_out = fwd_a + alu_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.alu        <= alu_out;
            ex_mem.store_data <= fwd_b;
        end
    end

    // Memory
    assign dmem_addr  = ex_mem.alu[$clog2(`PIPE_DMEM_DEPTH)-1:0];
    assign mem_result = ex_mem.ctrl.mem_read ? dmem[dmem_addr] : ex_mem.alu;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PIPE_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.ctrl.mem_write) begin
            dmem[dmem_addr] <= ex_mem.store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.ctrl.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.data      <= mem_result;
        end
    end

    // Writeback never writes register 0
    assign wb_valid = mem_wb.valid && mem_wb.reg_write;
    assign wb_rd    = mem_wb.rd;
    assign wb_data  = mem_wb.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && wb_rd != 3'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

endmodule

// File: logic/pipe_tracker.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipe_tracker (
    input  logic                    clk,
    input  logic                    rst,
    input  pipe_pkg::stage_status_t status,
    input  logic                    wb_valid,
    input  logic [2:0]              wb_rd,
    input  logic [`PIPE_XLEN-1:0]   wb_data,
    output logic                    retire_valid,
    output pipe_pkg::retire_t       retire
);
    import pipe_pkg::*;

    typedef struct packed {
        logic                     valid;
        logic [`PIPE_PC_W-1:0]    pc;
        instr_u                   instr;
        logic [`PIPE_CYCLE_W-1:0] fetch_cycle;
        logic [7:0]               hold_cycles;
    } track_rec_t;

    logic [`PIPE_CYCLE_W-1:0] cycle;

    track_rec_t fetch_rec;
    track_rec_t fetch_now;
    track_rec_t dec_rec;
    track_rec_t ex_rec;
    track_rec_t mem_rec;
    track_rec_t wb_rec;

    // Count one held cycle, saturating
    function automatic track_rec_t add_hold(input track_rec_t rec);
        track_rec_t res;
        res = rec;
        if (rec.valid && rec.hold_cycles != 8'hff) begin
            res.hold_cycles = rec.hold_cycles + 1'b1;
        end
        return res;
    endfunction

    // A new fetch opens a fresh record, otherwise the held one stays
    always_comb begin
        fetch_now = fetch_rec;
        if (status.fetch_fire) begin
            fetch_now.valid       = 1'b1;
            fetch_now.pc          = status.fetch_pc;
            fetch_now.instr       = status.fetch_instr;
            fetch_now.fetch_cycle = cycle;
            fetch_now.hold_cycles = 8'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle           <= '0;
            fetch_rec.valid <= 1'b0;
            dec_rec.valid   <= 1'b0;
            ex_rec.valid    <= 1'b0;
            mem_rec.valid   <= 1'b0;
            wb_rec.valid    <= 1'b0;
        end else begin
            cycle   <= cycle + 1'b1;
            mem_rec <= ex_rec;
            wb_rec  <= mem_rec;
            if (status.front_hold) begin
                fetch_rec    <= add_hold(fetch_now);
                dec_rec      <= add_hold(dec_rec);
                ex_rec.valid <= 1'b0;
            end else begin
                fetch_rec.valid <= 1'b0;
                dec_rec         <= fetch_now;
                ex_rec          <= dec_rec;
            end
        end
    end

    // Record in writeback completed with the result being written
    assign retire_valid = wb_rec.valid;

    always_comb begin
        retire.pc           = wb_rec.pc;
        retire.instr        = wb_rec.instr;
        retire.fetch_cycle  = wb_rec.fetch_cycle;
        retire.retire_cycle = cycle;
        retire.hold_cycles  = wb_rec.hold_cycles;
        retire.wrote        = wb_rec.valid && wb_valid;
        retire.rd           = wb_rd;
        retire.wb_data      = wb_data;
    end

endmodule

// File: logic/pipe_top.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipe_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  imem_we,
    input  logic [`PIPE_PC_W-1:0] imem_addr,
    input  logic [`PIPE_XLEN-1:0] imem_wdata,
    input  logic [`PIPE_PC_W:0]   prog_len,
    input  logic                  start,
    input  logic                  stall,
    output logic                  retire_valid,
    output pipe_pkg::retire_t     retire,
    output logic                  done
);
    import pipe_pkg::*;

    stage_status_t         status;
    logic                  wb_valid;
    logic [2:0]            wb_rd;
    logic [`PIPE_XLEN-1:0] wb_data;
    logic                  fetch_done;
    logic [2:0]            in_flight;
    logic [2:0]            in_flight_nxt;

    pipe_core core_i (
        .clk        (clk),
        .rst        (rst),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .prog_len   (prog_len),
        .start      (start),
        .stall      (stall),
        .status     (status),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .fetch_done (fetch_done)
    );

    pipe_tracker tracker_i (
        .clk          (clk),
        .rst          (rst),
        .status       (status),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    // Instructions between fetch and retire, at most five
    assign in_flight_nxt = in_flight + {2'b00, status.fetch_fire} - {2'b00, retire_valid};

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= 3'd0;
            done      <= 1'b0;
        end else begin
            in_flight <= in_flight_nxt;
            if (start) begin
                done <= 1'b0;
            end else if (fetch_done && in_flight_nxt == 3'd0) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// File: test/pipe_properties.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipe_properties (
    input logic                clk,
    input logic                rst,
    input logic                start,
    input logic [`PIPE_PC_W:0] prog_len,
    input logic                retire_valid,
    input pipe_pkg::retire_t   retire,
    input logic                done
);

    logic [`PIPE_PC_W:0] retire_count;

    // Retires since the last start
    always_ff @(posedge clk) begin
        if (rst || start) begin
            retire_count <= '0;
        end else if (retire_valid) begin
            retire_count <= retire_count + 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge clk) rst |=> !retire_valid && !done)
        else $error("retire_valid or done high right after reset");

    // Fetch to retire takes four cycles plus the held ones
    retire_span: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> (retire.retire_cycle - retire.fetch_cycle) == (16'd4 + retire.hold_cycles))
        else $error("retire record breaks the fetch to retire timing");

    done_no_retire: assert property (@(posedge clk) disable iff (rst) done |-> !retire_valid)
        else $error("retire_valid high while done is high");

    done_holds: assert property (@(posedge clk) disable iff (rst) done && !start |=> done)
        else $error("done fell without a start");

    done_after_last: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(retire_valid) && retire_count == prog_len)
        else $error("done rose without the full program retired just before");

endmodule

// File: test/pipe_tb.sv
`timescale 1ns/1ps
`include "pipe_macros.svh"

module pipe_tb;
    import pipe_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int NUM_ROWS       = 16;
    localparam int NUM_RUNS       = 2;
    localparam int CYCLES_PER_ROW = 40;
    localparam int DONE_CYCLES    = 6;

    // One program row and the result it must retire with
    typedef struct packed {
        logic [`PIPE_XLEN-1:0] word;
        logic                  wrote;
        logic [2:0]            rd;
        logic [`PIPE_XLEN-1:0] value;
        logic                  load_use;
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  imem_we;
    logic [`PIPE_PC_W-1:0] imem_addr;
    logic [`PIPE_XLEN-1:0] imem_wdata;
    logic [`PIPE_PC_W:0]   prog_len;
    logic                  start;
    logic                  stall = 1'b0;
    logic                  retire_valid;
    retire_t               retire;
    logic                  done;

    logic                  stall_en;
    logic [16:0]           lfsr = 17'd95592;
    int                    retired;
    int                    cycle_count;
    row_t                  prog_rows [NUM_ROWS];

    always #(CLK_PERIOD / 2) clk = ~clk;

    pipe_top pipe_top_i (
        .clk          (clk),
        .rst          (rst),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .prog_len     (prog_len),
        .start        (start),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire       (retire),
        .done         (done)
    );

    bind pipe_top pipe_properties props_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .prog_len     (prog_len),
        .retire_valid (retire_valid),
        .retire       (retire),
        .done         (done)
    );

    // Fibonacci LFSR with taps x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // One LFSR bit per cycle becomes the stall level
    always @(posedge clk) begin
        if (stall_en) begin
            lfsr  <= lfsr_step(lfsr);
            stall <= lfsr[16];
        end else begin
            stall <= 1'b0;
        end
    end

    // Free cycle count, zero after reset
    always @(posedge clk) begin
        if (rst) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%0h expected 0x%0h",
                                        name, got, exp));
        end
    endtask

    task automatic fill_table();
        // Arithmetic chain with back-to-back dependencies
        prog_rows[0]  = '{16'h3205, 1'b1, 3'd1, 16'h0005, 1'b0};
        prog_rows[1]  = '{16'h343d, 1'b1, 3'd2, 16'hfffd, 1'b0};
        prog_rows[2]  = '{16'h0650, 1'b1, 3'd3, 16'h0002, 1'b0};
        prog_rows[3]  = '{16'h18c8, 1'b1, 3'd4, 16'hfffd, 1'b0};
        prog_rows[4]  = '{16'h2b08, 1'b1, 3'd5, 16'h0005, 1'b0};
        prog_rows[5]  = '{16'h3d5f, 1'b1, 3'd6, 16'h0024, 1'b0};
        // Store to word 7, load it back, use the load at once
        prog_rows[6]  = '{16'h5c42, 1'b0, 3'd0, 16'h0000, 1'b0};
        prog_rows[7]  = '{16'h4e07, 1'b1, 3'd7, 16'h0024, 1'b0};
        prog_rows[8]  = '{16'h03f8, 1'b1, 3'd1, 16'h0048, 1'b1};
        // Loaded value as store data, then as a subtrahend
        prog_rows[9]  = '{16'h4407, 1'b1, 3'd2, 16'h0024, 1'b0};
        prog_rows[10] = '{16'h557d, 1'b0, 3'd0, 16'h0000, 1'b1};
        prog_rows[11] = '{16'h4602, 1'b1, 3'd3, 16'h0024, 1'b0};
        prog_rows[12] = '{16'h1818, 1'b1, 3'd4, 16'hffdc, 1'b1};
        prog_rows[13] = '{16'h2b10, 1'b1, 3'd5, 16'h0004, 1'b0};
        prog_rows[14] = '{16'hf000, 1'b0, 3'd0, 16'h0000, 1'b0};
        prog_rows[15] = '{16'h3f20, 1'b1, 3'd7, 16'hffbc, 1'b0};
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= i[`PIPE_PC_W-1:0];
            imem_wdata <= prog_rows[i].word;
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic check_retire(input int idx, input logic with_stall);
        row_t        row;
        logic        prev_use;
        logic [15:0] span;
        int          exp_hold;
        row      = prog_rows[idx];
        prev_use = 1'b0;
        if (idx > 0) begin
            prev_use = prog_rows[idx - 1].load_use;
        end
        // A load-use hold also keeps the next instruction in fetch
        exp_hold = int'(row.load_use) + int'(prev_use);
        span     = retire.retire_cycle - retire.fetch_cycle;
        check_value("retire.pc", retire.pc, idx);
        check_value("retire.instr", retire.instr, row.word);
        check_value("retire.wrote", retire.wrote, row.wrote);
        if (row.wrote) begin
            check_value("retire.rd", retire.rd, row.rd);
            check_value("retire.wb_data", retire.wb_data, row.value);
        end
        check_value("retire.retire_cycle", retire.retire_cycle, cycle_count);
        check_value("retire_cycle - fetch_cycle", span, 16'd4 + retire.hold_cycles);
        if (!with_stall) begin
            check_value("retire.hold_cycles", retire.hold_cycles, exp_hold);
        end
        if (row.load_use && retire.hold_cycles == 8'd0) begin
            stop_with_failure($sformatf("Load-use instruction at pc %0d retired without a hold",
                                        idx));
        end
    endtask

    task automatic run_program(input logic with_stall);
        int idx;
        int n;
        @(posedge clk);
        start    <= 1'b1;
        stall_en <= with_stall;
        @(posedge clk);
        start    <= 1'b0;
        prog_len <= NUM_ROWS[`PIPE_PC_W:0];
        for (idx = 0; idx < NUM_ROWS; idx++) begin
            // done stays low until the last instruction has retired
            do begin
                @(negedge clk);
                check_value("done", done, 1'b0);
            end while (!retire_valid);
            check_retire(idx, with_stall);
            retired++;
        end
        for (n = 0; n <= DONE_CYCLES; n++) begin
            @(negedge clk);
            check_value("done", done, 1'b1);
            check_value("retire_valid", retire_valid, 1'b0);
        end
    endtask

    // Watchdog sized from the table length and the number of runs
    initial begin
        #(CLK_PERIOD * (NUM_RUNS * NUM_ROWS * CYCLES_PER_ROW + 100));
        stop_with_failure($sformatf("Timeout: only %0d of %0d instructions retired",
                                    retired, NUM_RUNS * NUM_ROWS));
    end

    initial begin
        rst        = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        prog_len   = '0;
        start      = 1'b0;
        stall_en   = 1'b0;
        retired    = 0;
        fill_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("done", done, 1'b0);
        check_value("retire_valid", retire_valid, 1'b0);
        load_program();
        // Same program run without and then with external stalls
        run_program(1'b0);
        run_program(1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/pipe_pkg.sv
logic/instr_decoder.sv
logic/pipe_core.sv
logic/pipe_tracker.sv
logic/pipe_top.sv
test/pipe_properties.sv
test/pipe_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pipe_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
